// File: mem_bus_pkg.sv
package mem_bus_pkg;

	// One bus word is 32 bits wide and carries four byte lanes
	typedef logic [31:0] word;

	// Word address; byte offsets are not carried on the bus
	typedef logic [29:0] ptr;

	// Byte-enable mask selecting every lane of a word
	localparam logic [3:0] BE_ALL = 4'b1111;

	// Request presented by a master and forwarded to the memory
	typedef struct packed {
		ptr         addr;
		logic       write;
		word        data_wr;
		logic [3:0] be;
	} bus_req_t;

endpackage

// File: core_port_pkg.sv
package core_port_pkg;

	// Burst of sequential instruction words starting at start_pc
	typedef struct packed {
		mem_bus_pkg::ptr start_pc;
		logic [7:0]      count;
	} fetch_cmd_t;

	// One fetched instruction together with its word address
	typedef struct packed {
		mem_bus_pkg::ptr  pc;
		mem_bus_pkg::word insn;
	} insn_t;

	// Single load or byte-masked store
	typedef struct packed {
		mem_bus_pkg::ptr  addr;
		logic             write;
		mem_bus_pkg::word data;
		logic [3:0]       be;
	} lsu_cmd_t;

	// Completion of a data access; data is zero for a store
	typedef struct packed {
		mem_bus_pkg::ptr  addr;
		mem_bus_pkg::word data;
	} lsu_rsp_t;

endpackage

// File: core_mmu_arbiter.sv
module core_mmu_arbiter (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  bus_ready,
	input  mem_bus_pkg::word      bus_data_rd,
	input  mem_bus_pkg::bus_req_t insn_req,
	input  logic                  insn_start,
	input  mem_bus_pkg::bus_req_t data_req,
	input  logic                  data_start,

	output mem_bus_pkg::bus_req_t bus_req,
	output logic                  bus_start,
	output logic                  insn_ready,
	output logic                  data_ready,
	output mem_bus_pkg::word      insn_data_rd,
	output mem_bus_pkg::word      data_data_rd
);

	typedef enum logic {
		OWN_INSN,
		OWN_DATA
	} owner_t;

	owner_t owner;
	owner_t next_owner;

	logic active;
	logic hold_start;
	logic hold_issue;
	logic hold_free;
	logic transition;

	mem_bus_pkg::bus_req_t hold_req;
	mem_bus_pkg::bus_req_t insn_req_ro;

	// Both masters see the same read data; ready tells them apart
	assign insn_data_rd = bus_data_rd;
	assign data_data_rd = bus_data_rd;

	always_comb begin
		// The instruction side can only ever read whole words
		insn_req_ro = insn_req;
		insn_req_ro.write = 1'b0;
		insn_req_ro.be = mem_bus_pkg::BE_ALL;

		// Ownership may only move while the bus is idle or an access completes
		next_owner = owner;
		if (bus_ready || !active) begin
			unique case (owner)
				OWN_DATA: next_owner = data_start ? OWN_DATA : OWN_INSN;
				OWN_INSN: next_owner = (data_start || hold_start) ? OWN_DATA : OWN_INSN;
			endcase
		end

		transition = owner != next_owner;
		hold_issue = transition && hold_start;
		hold_free = transition || !hold_start;

		insn_ready = 1'b0;
		data_ready = 1'b0;
		unique case (owner)
			OWN_INSN: insn_ready = bus_ready;
			OWN_DATA: data_ready = bus_ready;
		endcase

		unique case (next_owner)
			OWN_INSN: begin
				bus_req = insn_req_ro;
				bus_start = insn_start;
			end
			OWN_DATA: begin
				bus_req = data_req;
				bus_start = data_start;
			end
		endcase

		// A deferred request goes out as soon as its side takes the bus
		if (hold_issue) begin
			bus_req = hold_req;
			bus_start = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			owner <= OWN_INSN;
			active <= 1'b0;
			hold_start <= 1'b0;
		end else begin
			owner <= next_owner;
			active <= bus_start || (active && !bus_ready);
			if (hold_free)
				hold_start <= (next_owner == OWN_INSN) ? data_start : insn_start;
		end
	end

	// The hold keeps whatever the losing side offered this cycle
	always_ff @(posedge clk) begin
		if (hold_free)
			hold_req <= (next_owner == OWN_INSN) ? data_req : insn_req_ro;
	end

endmodule

// File: core_fetch.sv
module core_fetch (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     fetch_go,
	input  core_port_pkg::fetch_cmd_t fetch_cmd,
	input  logic                     insn_ready,
	input  mem_bus_pkg::word         insn_data_rd,

	output mem_bus_pkg::bus_req_t    insn_req,
	output logic                     insn_start,
	output logic                     insn_valid,
	output core_port_pkg::insn_t     insn_out,
	output logic                     fetch_busy
);

	mem_bus_pkg::ptr pc;
	logic [7:0]      remaining;
	logic            first_start;
	logic            last;

	assign last = remaining == 8'd1;
	assign insn_valid = fetch_busy && insn_ready;

	// The next read leaves in the same cycle that the previous word returns
	assign insn_start = first_start || (insn_valid && !last);

	always_comb begin
		insn_req.addr = insn_valid ? pc + 30'd1 : pc;
		insn_req.write = 1'b0;
		insn_req.data_wr = '0;
		insn_req.be = mem_bus_pkg::BE_ALL;

		insn_out.pc = pc;
		insn_out.insn = insn_data_rd;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_busy <= 1'b0;
			first_start <= 1'b0;
			remaining <= 8'd0;
		end else begin
			first_start <= 1'b0;
			if (fetch_go && !fetch_busy) begin
				remaining <= fetch_cmd.count;
				if (fetch_cmd.count != 8'd0) begin
					fetch_busy <= 1'b1;
					first_start <= 1'b1;
				end
			end else if (insn_valid) begin
				remaining <= remaining - 8'd1;
				if (last)
					fetch_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_go && !fetch_busy)
			pc <= fetch_cmd.start_pc;
		else if (insn_valid)
			pc <= pc + 30'd1;
	end

endmodule

// File: core_lsu.sv
module core_lsu (
	input  logic                    clk,
	input  logic                    rst_n,

	input  logic                    lsu_go,
	input  core_port_pkg::lsu_cmd_t lsu_cmd,
	input  logic                    data_ready,
	input  mem_bus_pkg::word        data_data_rd,

	output mem_bus_pkg::bus_req_t   data_req,
	output logic                    data_start,
	output logic                    lsu_done,
	output core_port_pkg::lsu_rsp_t lsu_rsp,
	output logic                    lsu_busy
);

	core_port_pkg::lsu_cmd_t cmd_q;
	logic                    start_q;

	assign data_start = start_q;
	assign lsu_done = lsu_busy && data_ready;

	always_comb begin
		data_req.addr = cmd_q.addr;
		data_req.write = cmd_q.write;
		data_req.data_wr = cmd_q.data;
		data_req.be = cmd_q.be;

		lsu_rsp.addr = cmd_q.addr;
		// Stores report no data back to the core
		lsu_rsp.data = cmd_q.write ? '0 : data_data_rd;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lsu_busy <= 1'b0;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			if (lsu_go && !lsu_busy) begin
				lsu_busy <= 1'b1;
				start_q <= 1'b1;
			end else if (lsu_done) begin
				lsu_busy <= 1'b0;
			end
		end
	end

	// A command arriving while busy is dropped
	always_ff @(posedge clk) begin
		if (lsu_go && !lsu_busy)
			cmd_q <= lsu_cmd;
	end

endmodule

// File: bus_sram.sv
module bus_sram #(
	parameter int unsigned MEM_WORDS   = 256,
	parameter int unsigned WAIT_STATES = 2
) (
	input  logic                  clk,
	input  logic                  rst_n,

	input  mem_bus_pkg::bus_req_t bus_req,
	input  logic                  bus_start,

	output logic                  bus_ready,
	output mem_bus_pkg::word      bus_data_rd
);

	localparam int unsigned AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int unsigned CW = $clog2(WAIT_STATES + 2);

	mem_bus_pkg::word mem [MEM_WORDS];

	mem_bus_pkg::bus_req_t req_q;
	mem_bus_pkg::bus_req_t acc_req;
	logic                  pending;
	logic [CW-1:0]         wait_cnt;
	logic                  do_acc;
	logic [AW-1:0]         idx;

	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	// With no wait states the access happens on the start edge itself
	always_comb begin
		if (WAIT_STATES == 0) begin
			do_acc = bus_start;
			acc_req = bus_req;
		end else begin
			do_acc = pending && (wait_cnt == CW'(1));
			acc_req = req_q;
		end
		idx = AW'(acc_req.addr % mem_bus_pkg::ptr'(MEM_WORDS));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
			wait_cnt <= '0;
			bus_ready <= 1'b0;
		end else begin
			bus_ready <= do_acc;
			if (bus_start && WAIT_STATES != 0) begin
				pending <= 1'b1;
				wait_cnt <= CW'(WAIT_STATES);
			end else if (do_acc) begin
				pending <= 1'b0;
			end else if (pending) begin
				wait_cnt <= wait_cnt - CW'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus_start)
			req_q <= bus_req;

		if (do_acc) begin
			// Read data is the word as it stood before any write
			bus_data_rd <= mem[idx];
			if (acc_req.write) begin
				for (int b = 0; b < 4; b++) begin
					if (acc_req.be[b])
						mem[idx][8*b +: 8] <= acc_req.data_wr[8*b +: 8];
				end
			end
		end
	end

endmodule

// File: core_mem_top.sv
module core_mem_top #(
	parameter int unsigned MEM_WORDS   = 256,
	parameter int unsigned WAIT_STATES = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic                      fetch_go,
	input  core_port_pkg::fetch_cmd_t fetch_cmd,
	input  logic                      lsu_go,
	input  core_port_pkg::lsu_cmd_t   lsu_cmd,

	output logic                      insn_valid,
	output core_port_pkg::insn_t      insn_out,
	output logic                      fetch_busy,
	output logic                      lsu_done,
	output core_port_pkg::lsu_rsp_t   lsu_rsp,
	output logic                      lsu_busy
);

	mem_bus_pkg::bus_req_t insn_req;
	mem_bus_pkg::bus_req_t data_req;
	mem_bus_pkg::bus_req_t bus_req;
	logic                  insn_start;
	logic                  data_start;
	logic                  bus_start;
	logic                  insn_ready;
	logic                  data_ready;
	logic                  bus_ready;
	mem_bus_pkg::word      insn_data_rd;
	mem_bus_pkg::word      data_data_rd;
	mem_bus_pkg::word      bus_data_rd;

	core_fetch u_core_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_go     (fetch_go),
		.fetch_cmd    (fetch_cmd),
		.insn_ready   (insn_ready),
		.insn_data_rd (insn_data_rd),
		.insn_req     (insn_req),
		.insn_start   (insn_start),
		.insn_valid   (insn_valid),
		.insn_out     (insn_out),
		.fetch_busy   (fetch_busy)
	);

	core_lsu u_core_lsu (
		.clk          (clk),
		.rst_n        (rst_n),
		.lsu_go       (lsu_go),
		.lsu_cmd      (lsu_cmd),
		.data_ready   (data_ready),
		.data_data_rd (data_data_rd),
		.data_req     (data_req),
		.data_start   (data_start),
		.lsu_done     (lsu_done),
		.lsu_rsp      (lsu_rsp),
		.lsu_busy     (lsu_busy)
	);

	core_mmu_arbiter u_core_mmu_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.bus_ready    (bus_ready),
		.bus_data_rd  (bus_data_rd),
		.insn_req     (insn_req),
		.insn_start   (insn_start),
		.data_req     (data_req),
		.data_start   (data_start),
		.bus_req      (bus_req),
		.bus_start    (bus_start),
		.insn_ready   (insn_ready),
		.data_ready   (data_ready),
		.insn_data_rd (insn_data_rd),
		.data_data_rd (data_data_rd)
	);

	bus_sram #(
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_STATES (WAIT_STATES)
	) u_bus_sram (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus_req     (bus_req),
		.bus_start   (bus_start),
		.bus_ready   (bus_ready),
		.bus_data_rd (bus_data_rd)
	);

endmodule

// File: core_mem_chk.sv
module core_mem_chk (
	input logic clk,
	input logic rst_n,
	input logic insn_ready,
	input logic data_ready,
	input logic bus_start,
	input logic hold_start,
	input logic hold_issue
);

	// A held request waits for at most one access in flight and the hand-over
	localparam int unsigned HOLD_MAX = 8;

	int unsigned hold_age;
	int unsigned violations = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			hold_age <= 0;
		else if (hold_start && !hold_issue)
			hold_age <= hold_age + 1;
		else
			hold_age <= 0;
	end

	ready_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(insn_ready && data_ready))
		else begin
			$error("insn_ready and data_ready are high in the same cycle");
			violations = violations + 1;
		end

	start_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !bus_start)
		else begin
			$error("bus_start is high while reset is asserted");
			violations = violations + 1;
		end

	hold_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		hold_age < HOLD_MAX)
		else begin
			$error("Deferred request was not issued within %0d cycles", HOLD_MAX);
			violations = violations + 1;
		end

endmodule

bind core_mmu_arbiter core_mem_chk u_core_mem_chk (.*);

// File: tb_core_mem.sv
module tb_core_mem;

	localparam int MODEL_WORDS = 256;
	localparam int TIMEOUT_CYCLES = 200;

	logic                      clk;
	logic                      rst_n;
	logic                      fetch_go;
	core_port_pkg::fetch_cmd_t fetch_cmd;
	logic                      lsu_go;
	core_port_pkg::lsu_cmd_t   lsu_cmd;
	logic                      insn_valid;
	core_port_pkg::insn_t      insn_out;
	logic                      fetch_busy;
	logic                      lsu_done;
	core_port_pkg::lsu_rsp_t   lsu_rsp;
	logic                      lsu_busy;

	logic [31:0]      rng_state;
	mem_bus_pkg::word model [MODEL_WORDS];

	core_mem_top u_core_mem_top (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// The memory wraps addresses modulo its depth
	function automatic int model_index(input mem_bus_pkg::ptr a);
		return int'(a % mem_bus_pkg::ptr'(MODEL_WORDS));
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
			abort_run("A control output has the wrong level");
		end
	endtask

	task automatic check_insn(input core_port_pkg::insn_t got,
			input core_port_pkg::insn_t exp, input string name);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = pc %h insn %h, expected pc %h insn %h",
				$time, name, got.pc, got.insn, exp.pc, exp.insn);
			abort_run("A fetched instruction is wrong");
		end
	endtask

	task automatic check_lsu_rsp(input core_port_pkg::lsu_rsp_t got,
			input core_port_pkg::lsu_rsp_t exp, input string name);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s = addr %h data %h, expected addr %h data %h",
				$time, name, got.addr, got.data, exp.addr, exp.data);
			abort_run("A load/store response is wrong");
		end
	endtask

	task automatic lsu_access(input mem_bus_pkg::ptr addr, input logic write,
			input mem_bus_pkg::word data, input logic [3:0] be);
		core_port_pkg::lsu_cmd_t cmd;
		core_port_pkg::lsu_rsp_t exp;
		int                      cycles;
		cmd.addr = addr;
		cmd.write = write;
		cmd.data = data;
		cmd.be = be;
		exp.addr = addr;
		exp.data = write ? '0 : model[model_index(addr)];
		@(posedge clk);
		#1;
		lsu_go = 1'b1;
		lsu_cmd = cmd;
		@(posedge clk);
		#1;
		lsu_go = 1'b0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				abort_run("Timed out waiting for lsu_done");
			// The unit stays busy from the accepted command up to its completion
			check_bit(lsu_busy, 1'b1, "lsu_busy");
		end while (!lsu_done);
		check_lsu_rsp(lsu_rsp, exp, "lsu_rsp");
		if (write) begin
			for (int b = 0; b < 4; b++) begin
				if (be[b])
					model[model_index(addr)][8*b +: 8] = data[8*b +: 8];
			end
		end
	endtask

	task automatic fill_region(input mem_bus_pkg::ptr start, input int count);
		for (int i = 0; i < count; i++)
			lsu_access(start + mem_bus_pkg::ptr'(i), 1'b1, xorshift32(), 4'hf);
	endtask

	task automatic start_fetch(input mem_bus_pkg::ptr start_pc, input logic [7:0] count);
		@(posedge clk);
		#1;
		fetch_go = 1'b1;
		fetch_cmd.start_pc = start_pc;
		fetch_cmd.count = count;
		@(posedge clk);
		#1;
		fetch_go = 1'b0;
	endtask

	// Words must come back in order, one insn_valid pulse each
	task automatic collect_burst(input mem_bus_pkg::ptr start_pc, input int count);
		core_port_pkg::insn_t exp;
		int                   cycles;
		for (int i = 0; i < count; i++) begin
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
				if (cycles > TIMEOUT_CYCLES)
					abort_run("Timed out waiting for insn_valid");
			end while (!insn_valid);
			exp.pc = start_pc + mem_bus_pkg::ptr'(i);
			exp.insn = model[model_index(exp.pc)];
			check_insn(insn_out, exp, "insn_out");
		end
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				abort_run("Timed out waiting for fetch_busy to fall");
			if (insn_valid)
				abort_run("The fetch unit returned more words than the burst asked for");
		end while (fetch_busy);
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_bit(insn_valid, 1'b0, "insn_valid");
		check_bit(lsu_done, 1'b0, "lsu_done");
		check_bit(fetch_busy, 1'b0, "fetch_busy");
		check_bit(lsu_busy, 1'b0, "lsu_busy");
	endtask

	task automatic test_store_load();
		mem_bus_pkg::ptr addrs [8];
		for (int i = 0; i < 8; i++) begin
			addrs[i] = mem_bus_pkg::ptr'(xorshift32());
			lsu_access(addrs[i], 1'b1, xorshift32(), 4'hf);
		end
		for (int i = 0; i < 8; i++)
			lsu_access(addrs[i], 1'b0, '0, 4'hf);
	endtask

	task automatic test_byte_enables();
		mem_bus_pkg::ptr addr;
		addr = mem_bus_pkg::ptr'(xorshift32());
		lsu_access(addr, 1'b1, xorshift32(), 4'hf);
		for (int b = 0; b < 4; b++) begin
			lsu_access(addr, 1'b1, xorshift32(), 4'(1 << b));
			lsu_access(addr, 1'b0, '0, 4'hf);
		end
	endtask

	task automatic test_fetch_burst();
		fill_region(30'h10, 16);
		start_fetch(30'h10, 8'd16);
		collect_burst(30'h10, 16);
	endtask

	task automatic test_contention();
		logic [31:0]     r;
		mem_bus_pkg::ptr addr;
		fill_region(30'h40, 24);
		start_fetch(30'h40, 8'd24);
		fork
			collect_burst(30'h40, 24);
			begin
				// Data traffic stays in the upper half, away from the fetched words
				for (int i = 0; i < 10; i++) begin
					r = xorshift32();
					addr = {r[29:8], 1'b1, r[6:0]};
					lsu_access(addr, r[31], xorshift32(), r[3:0]);
				end
			end
		join
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		fetch_go = 1'b0;
		fetch_cmd = '0;
		lsu_go = 1'b0;
		lsu_cmd = '0;
		rng_state = 32'heb6b_3fdc;
		for (int i = 0; i < MODEL_WORDS; i++)
			model[i] = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_store_load();
		test_byte_enables();
		test_fetch_burst();
		test_contention();
		if (u_core_mem_top.u_core_mmu_arbiter.u_core_mem_chk.violations != 0) begin
			abort_run("Bus protocol assertions failed during the run");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: build.f
mem_bus_pkg.sv
core_port_pkg.sv
core_mmu_arbiter.sv
core_fetch.sv
core_lsu.sv
bus_sram.sv
core_mem_top.sv
core_mem_chk.sv
tb_core_mem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_mem
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
